//--- logic/cpu_types_pkg.sv
// cpu cache shared types
package cpu_types_pkg;

  parameter int WORD_W = 32;
  parameter int TAG_W  = 26;
  parameter int IDX_W  = 3;
  parameter int SETS   = 8;
  parameter int WAYS   = 2;

  typedef logic [WORD_W-1:0] word_t;

  // hit statistic lands here after the flush
  parameter word_t STAT_ADDR = 32'h00003100;

  // byte address as the cache sees it
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] idx;
    logic             blkoff;  // word within the block
    logic [1:0]       bytoff;
  } dcachef_t;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    word_t [1:0]      data;
    logic             valid;
    logic             dirty;
  } cache_entry_t;

  // datapath side
  typedef struct packed {
    logic  ren;
    logic  wen;
    logic  halt;   // level, held by the datapath
    word_t addr;
    word_t store;
  } dp_req_t;

  typedef struct packed {
    logic  hit;
    logic  flushed;  // sticky once the statistic is written
    word_t load;
  } dp_rsp_t;

  // memory side
  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
  } mem_req_t;

  typedef struct packed {
    logic  dwait;  // access still in progress
    word_t load;
  } mem_rsp_t;

  typedef enum logic [3:0] {
    IDLE,
    LOAD0, LOAD1,
    WB_READ0, WB_READ1,
    WB_WRITE0, WB_WRITE1,
    ALLOC_TAG, ALLOC_FILL,
    FLUSH_SCAN, FLUSH_WB0, FLUSH_WB1,
    STAT_WRITE,
    DONE
  } dcache_state_t;

endpackage

//--- logic/dcache_array.sv
// data cache storage array
module dcache_array (
  input  logic                              CLK,
  input  logic                              nRST,
  input  logic [cpu_types_pkg::IDX_W-1:0]   idx,
  input  logic [cpu_types_pkg::TAG_W-1:0]   tag,
  input  logic [cpu_types_pkg::WAYS-1:0]    we,
  input  cpu_types_pkg::cache_entry_t       entry_nxt,
  input  logic                              lru_we,
  input  logic                              lru_nxt,
  output cpu_types_pkg::cache_entry_t       way0,
  output cpu_types_pkg::cache_entry_t       way1,
  output logic                              lru,
  output logic                              hit0,
  output logic                              hit1
);
  import cpu_types_pkg::*;

  cache_entry_t    entries [WAYS][SETS];
  logic [SETS-1:0] lru_bits;  // set means way 1 is the older one

  // single write port, one way per edge
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      for (int w = 0; w < WAYS; w++)
      begin
        for (int s = 0; s < SETS; s++)
        begin
          entries[w][s] <= '0;
        end
      end
      lru_bits <= '0;
    end
    else
    begin
      for (int w = 0; w < WAYS; w++)
      begin
        if (we[w])
        begin
          entries[w][idx] <= entry_nxt;
        end
      end
      if (lru_we)
      begin
        lru_bits[idx] <= lru_nxt;
      end
    end
  end

  // both ways of the set are read every cycle
  assign way0 = entries[0][idx];
  assign way1 = entries[1][idx];
  assign lru  = lru_bits[idx];

  assign hit0 = way0.valid && (way0.tag == tag);
  assign hit1 = way1.valid && (way1.tag == tag);

endmodule

//--- logic/dcache.sv
// data cache controller
module dcache (
  input  logic                    CLK,
  input  logic                    nRST,
  input  cpu_types_pkg::dp_req_t  dp_req,
  output cpu_types_pkg::dp_rsp_t  dp_rsp,
  output cpu_types_pkg::mem_req_t mem_req,
  input  cpu_types_pkg::mem_rsp_t mem_rsp
);
  import cpu_types_pkg::*;

  dcache_state_t state, state_nxt;
  logic [3:0]    count, count_nxt;  // flush position, msb picks the way
  word_t         hit_count, hit_count_nxt;

  dcachef_t         q;
  logic             req;
  logic             mem_done;
  logic             in_flush;
  logic             second;    // upper word of a two-word transfer
  logic             sel_way;
  logic [IDX_W-1:0] arr_idx;
  logic [WAYS-1:0]  arr_we;
  logic [WAYS-1:0]  vic_we;
  cache_entry_t     entry_nxt;
  cache_entry_t     way0, way1;
  cache_entry_t     vic;       // block being replaced or flushed
  logic             lru, lru_we, lru_nxt;
  logic             hit0, hit1;

  assign q        = dcachef_t'(dp_req.addr);
  assign req      = dp_req.ren || dp_req.wen;
  assign mem_done = !mem_rsp.dwait;
  assign in_flush = state inside {FLUSH_SCAN, FLUSH_WB0, FLUSH_WB1};
  assign second   = state inside {LOAD1, WB_READ1, WB_WRITE1, FLUSH_WB1};

  // the flush walks the array with the counter instead of the address
  assign arr_idx = in_flush ? count[2:0] : q.idx;
  assign sel_way = in_flush ? count[3] : lru;
  assign vic     = sel_way ? way1 : way0;
  assign vic_we  = WAYS'(1) << sel_way;

  dcache_array u_array (
    .CLK       (CLK),
    .nRST      (nRST),
    .idx       (arr_idx),
    .tag       (q.tag),
    .we        (arr_we),
    .entry_nxt (entry_nxt),
    .lru_we    (lru_we),
    .lru_nxt   (lru_nxt),
    .way0      (way0),
    .way1      (way1),
    .lru       (lru),
    .hit0      (hit0),
    .hit1      (hit1)
  );

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      state     <= IDLE;
      count     <= '0;
      hit_count <= '0;
    end
    else
    begin
      state     <= state_nxt;
      count     <= count_nxt;
      hit_count <= hit_count_nxt;
    end
  end

  // memory requests depend on state only, so they hold through dwait
  always_comb
  begin
    mem_req = '0;
    case (state)
      LOAD0, LOAD1:
      begin
        mem_req.ren  = 1'b1;
        mem_req.addr = {q.tag, q.idx, second, 2'b00};
      end
      ALLOC_FILL:
      begin
        mem_req.ren  = 1'b1;
        mem_req.addr = {q.tag, q.idx, ~q.blkoff, 2'b00};  // the word not being written
      end
      WB_READ0, WB_READ1, WB_WRITE0, WB_WRITE1, FLUSH_WB0, FLUSH_WB1:
      begin
        mem_req.wen   = 1'b1;
        mem_req.addr  = {vic.tag, arr_idx, second, 2'b00};
        mem_req.store = vic.data[second];
      end
      STAT_WRITE:
      begin
        mem_req.wen   = 1'b1;
        mem_req.addr  = STAT_ADDR;
        mem_req.store = hit_count;
      end
      default: ;
    endcase
  end

  always_comb
  begin
    state_nxt     = state;
    count_nxt     = count;
    hit_count_nxt = hit_count;
    arr_we        = '0;
    entry_nxt     = vic;
    lru_we        = 1'b0;
    lru_nxt       = lru;
    dp_rsp        = '0;

    case (state)
      IDLE:
      begin
        if (req && (hit0 || hit1))
        begin
          dp_rsp.hit    = 1'b1;
          dp_rsp.load   = hit0 ? way0.data[q.blkoff] : way1.data[q.blkoff];
          hit_count_nxt = hit_count + 32'd1;
          lru_we        = 1'b1;
          lru_nxt       = hit0;  // the other way is now older
          if (dp_req.wen)
          begin
            entry_nxt                = hit0 ? way0 : way1;
            entry_nxt.data[q.blkoff] = dp_req.store;
            entry_nxt.dirty          = 1'b1;
            arr_we                   = {hit1, hit0};
          end
        end
        else if (req)
        begin
          // a retry after the fill counts the hit back
          hit_count_nxt = hit_count - 32'd1;
          if (vic.valid && vic.dirty)
            state_nxt = dp_req.ren ? WB_READ0 : WB_WRITE0;
          else
            state_nxt = dp_req.ren ? LOAD0 : ALLOC_TAG;
        end
        else if (dp_req.halt)
        begin
          count_nxt = '0;
          state_nxt = FLUSH_SCAN;
        end
      end
      WB_READ0:
        if (mem_done)
          state_nxt = WB_READ1;
      WB_READ1:
        if (mem_done)
          state_nxt = LOAD0;
      WB_WRITE0:
        if (mem_done)
          state_nxt = WB_WRITE1;
      WB_WRITE1:
        if (mem_done)
          state_nxt = ALLOC_TAG;
      LOAD0:
        if (mem_done)
        begin
          entry_nxt.data[0] = mem_rsp.load;
          entry_nxt.valid   = 1'b0;  // old block is gone from here on
          arr_we            = vic_we;
          state_nxt         = LOAD1;
        end
      LOAD1:
        if (mem_done)
        begin
          entry_nxt.tag     = q.tag;
          entry_nxt.data[1] = mem_rsp.load;
          entry_nxt.valid   = 1'b1;
          entry_nxt.dirty   = 1'b0;
          arr_we            = vic_we;
          state_nxt         = IDLE;
        end
      ALLOC_TAG:
      begin
        // claim the block, the store itself lands on the retry
        entry_nxt.tag   = q.tag;
        entry_nxt.valid = 1'b1;
        entry_nxt.dirty = 1'b0;
        arr_we          = vic_we;
        state_nxt       = ALLOC_FILL;
      end
      ALLOC_FILL:
        if (mem_done)
        begin
          entry_nxt.data[~q.blkoff] = mem_rsp.load;
          arr_we                    = vic_we;
          state_nxt                 = IDLE;
        end
      FLUSH_SCAN:
        if (vic.valid && vic.dirty)
          state_nxt = FLUSH_WB0;
        else if (count == 4'hf)
          state_nxt = STAT_WRITE;
        else
          count_nxt = count + 4'd1;
      FLUSH_WB0:
        if (mem_done)
          state_nxt = FLUSH_WB1;
      FLUSH_WB1:
        if (mem_done)
        begin
          entry_nxt.dirty = 1'b0;  // scan sees it clean and moves on
          arr_we          = vic_we;
          state_nxt       = FLUSH_SCAN;
        end
      STAT_WRITE:
        if (mem_done)
          state_nxt = DONE;
      DONE:
        dp_rsp.flushed = 1'b1;
      default:
        state_nxt = IDLE;
    endcase
  end

endmodule

//--- logic/ram.sv
// backing word memory
module ram #(
  parameter int RAM_LAT = 2
) (
  input  logic                    CLK,
  input  logic                    nRST,
  input  cpu_types_pkg::mem_req_t mem_req,
  output cpu_types_pkg::mem_rsp_t mem_rsp,
  input  cpu_types_pkg::word_t    dbg_addr,
  output cpu_types_pkg::word_t    dbg_data
);
  import cpu_types_pkg::*;

  localparam int DEPTH = 4096;
  localparam int AW    = $clog2(DEPTH);
  localparam int CNT_W = (RAM_LAT < 2) ? 1 : $clog2(RAM_LAT + 1);
  localparam logic [CNT_W-1:0] LAT = CNT_W'(RAM_LAT);

  word_t            mem [DEPTH];
  logic [CNT_W-1:0] cnt;    // wait cycles spent on the current access
  logic             access;
  logic             busy;
  logic [AW-1:0]    maddr;
  logic [AW-1:0]    daddr;

  assign access = mem_req.ren || mem_req.wen;
  assign busy   = access && (cnt != LAT);
  assign maddr  = mem_req.addr[AW+1:2];  // word addressed
  assign daddr  = dbg_addr[AW+1:2];

  // restarts from zero after each completion
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      cnt <= '0;
    else if (busy)
      cnt <= cnt + 1'b1;
    else
      cnt <= '0;
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      for (int i = 0; i < DEPTH; i++)
      begin
        mem[i] <= '0;
      end
    end
    else if (mem_req.wen && !busy)
    begin
      mem[maddr] <= mem_req.store;
    end
  end

  assign mem_rsp.dwait = busy;
  assign mem_rsp.load  = mem[maddr];
  assign dbg_data      = mem[daddr];  // bypasses the wait counter

endmodule

//--- logic/mem_subsystem.sv
// cache and memory top level
module mem_subsystem #(
  parameter int RAM_LAT = 2
) (
  input  logic                   CLK,
  input  logic                   nRST,
  input  cpu_types_pkg::dp_req_t dp_req,
  output cpu_types_pkg::dp_rsp_t dp_rsp,
  input  cpu_types_pkg::word_t   dbg_addr,
  output cpu_types_pkg::word_t   dbg_data
);
  import cpu_types_pkg::*;

  mem_req_t mem_req;  // cache to ram
  mem_rsp_t mem_rsp;

  dcache u_dcache (
    .CLK     (CLK),
    .nRST    (nRST),
    .dp_req  (dp_req),
    .dp_rsp  (dp_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  ram #(
    .RAM_LAT (RAM_LAT)
  ) u_ram (
    .CLK      (CLK),
    .nRST     (nRST),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data)
  );

endmodule

//--- testbench/dcache_assertions.sv
// cache port assertions
module dcache_assertions (
  input logic                    CLK,
  input logic                    nRST,
  input cpu_types_pkg::dp_req_t  dp_req,
  input cpu_types_pkg::dp_rsp_t  dp_rsp,
  input cpu_types_pkg::mem_req_t mem_req,
  input cpu_types_pkg::mem_rsp_t mem_rsp,
  input cpu_types_pkg::word_t    exp_load,  // shadow word for the current read
  input logic                    exp_chk
);
  timeunit 1ns;
  timeprecision 100ps;

  int fails = 0;  // failure count, summed into the testbench totals

  hit_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
    dp_rsp.hit |-> (dp_req.ren || dp_req.wen))
  else
  begin
    fails++;
    $error("hit raised while no request was pending");
  end

  mem_one_op: assert property (@(posedge CLK) disable iff (!nRST)
    !(mem_req.ren && mem_req.wen))
  else
  begin
    fails++;
    $error("memory read and write requested together");
  end

  // request must not move while the ram holds wait
  mem_held: assert property (@(posedge CLK) disable iff (!nRST)
    ((mem_req.ren || mem_req.wen) && mem_rsp.dwait) |=> $stable(mem_req))
  else
  begin
    fails++;
    $error("memory request changed during wait");
  end

  flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
    dp_rsp.flushed |=> dp_rsp.flushed)
  else
  begin
    fails++;
    $error("flushed dropped after it was reached");
  end

  load_matches: assert property (@(posedge CLK) disable iff (!nRST)
    (dp_rsp.hit && dp_req.ren && exp_chk) |-> (dp_rsp.load == exp_load))
  else
  begin
    fails++;
    $error("load %h at %h, shadow holds %h", dp_rsp.load, dp_req.addr, exp_load);
  end

endmodule

//--- testbench/mem_subsystem_tb.sv
// cache subsystem testbench
module mem_subsystem_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import cpu_types_pkg::*;

  localparam int PERIOD    = 20;
  localparam int RAM_LAT   = 2;
  localparam int N_RAND    = 40;
  localparam int N_REQ     = 12 + N_RAND;
  localparam int N_WORDS   = 64;  // four tags over every set
  localparam int REQ_MAX   = 4 * (RAM_LAT + 1) + 4;  // dirty miss plus retry
  localparam int FLUSH_MAX = 16 * (2 * (RAM_LAT + 1) + 2) + RAM_LAT + 4;
  localparam int LIMIT     = 2 * (3 + N_REQ * REQ_MAX + FLUSH_MAX + N_WORDS + 2);

  logic             CLK;
  logic             nRST;
  dp_req_t          dp_req;
  dp_rsp_t          dp_rsp;
  word_t            dbg_addr;
  word_t            dbg_data;
  word_t            exp_load;
  logic             exp_chk;
  word_t            shadow [N_WORDS];
  logic [TAG_W-1:0] m_tag [2][SETS];   // own model of the cache tags
  logic             m_valid [2][SETS];
  logic             m_lru [SETS];
  integer           seed;
  int               first_hits;
  int               errors;
  int               tests_ok;
  int               tests_bad;

  mem_subsystem #(
    .RAM_LAT (RAM_LAT)
  ) UUT (
    .CLK      (CLK),
    .nRST     (nRST),
    .dp_req   (dp_req),
    .dp_rsp   (dp_rsp),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data)
  );

  bind dcache dcache_assertions u_chk (
    .CLK      (CLK),
    .nRST     (nRST),
    .dp_req   (dp_req),
    .dp_rsp   (dp_rsp),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp),
    .exp_load (mem_subsystem_tb.exp_load),
    .exp_chk  (mem_subsystem_tb.exp_chk)
  );

  always #(PERIOD / 2) CLK = ~CLK;

  function automatic int total_errors();
    return errors + UUT.u_dcache.u_chk.fails;
  endfunction

  task automatic finish_test(input string name, input int errs_before);
    if (total_errors() == errs_before)
    begin
      tests_ok++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_bad++;
      $display("test %s: %0d error(s)", name, total_errors() - errs_before);
    end
  endtask

  // hold one request until hit, checking the first cycle against the model
  task automatic access(input logic wr, input word_t addr, input word_t data);
    logic [IDX_W-1:0] s;
    logic [TAG_W-1:0] t;
    logic             pred;
    logic             way;
    logic             first;
    logic             done;
    s     = addr[5:3];
    t     = addr[31:6];
    pred  = (m_valid[0][s] && m_tag[0][s] == t) || (m_valid[1][s] && m_tag[1][s] == t);
    way   = (m_valid[1][s] && m_tag[1][s] == t) ? 1'b1 : (pred ? 1'b0 : m_lru[s]);
    first = 1'b1;
    done  = 1'b0;
    dp_req.ren   = !wr;
    dp_req.wen   = wr;
    dp_req.addr  = addr;
    dp_req.store = data;
    exp_load     = shadow[addr[7:2]];
    exp_chk      = !wr;
    while (!done)
    begin
      #(PERIOD / 2 - 1);  // just before the rising edge
      if (first)
      begin
        assert (dp_rsp.hit == pred)
        else
        begin
          errors++;
          $display("ERR %0t: addr %h first-try hit %b, expected %b",
                   $time, addr, dp_rsp.hit, pred);
        end
      end
      first = 1'b0;
      done  = dp_rsp.hit;
      @(negedge CLK);
    end
    dp_req.ren = 1'b0;
    dp_req.wen = 1'b0;
    exp_chk    = 1'b0;
    if (wr)
      shadow[addr[7:2]] = data;
    if (pred)
      first_hits++;
    m_tag[way][s]   = t;
    m_valid[way][s] = 1'b1;
    m_lru[s]        = !way;  // other way becomes the older one
  endtask

  task automatic check_word(input word_t addr, input word_t want);
    dbg_addr = addr;
    #(PERIOD / 2 - 1);
    assert (dbg_data == want)
    else
    begin
      errors++;
      $display("ERR %0t: memory %h holds %h, expected %h", $time, addr, dbg_data, want);
    end
    @(negedge CLK);
  endtask

  initial
  begin
    int          errs;
    logic [31:0] r;
    logic        done;
    CLK        = 1'b0;
    nRST       = 1'b0;
    dp_req     = '0;
    dbg_addr   = '0;
    exp_load   = '0;
    exp_chk    = 1'b0;
    shadow     = '{default: '0};
    m_tag      = '{default: '0};
    m_valid    = '{default: 1'b0};
    m_lru      = '{default: 1'b0};
    seed       = 32'h70e8a517;
    first_hits = 0;
    errors     = 0;
    tests_ok   = 0;
    tests_bad  = 0;
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;

    errs = total_errors();
    access(1'b0, 32'h0000_0000, '0);
    access(1'b0, 32'h0000_0000, '0);  // re-read hits at once
    access(1'b0, 32'h0000_004c, '0);
    access(1'b0, 32'h0000_0048, '0);
    finish_test("read fill", errs);

    errs = total_errors();
    access(1'b1, 32'h0000_0010, 32'hcafe_0010);  // write miss allocates
    access(1'b1, 32'h0000_0014, 32'hcafe_0014);
    access(1'b0, 32'h0000_0010, '0);
    access(1'b0, 32'h0000_0014, '0);
    finish_test("write read", errs);

    // set 5 with tags 1, 2 and 3
    errs = total_errors();
    access(1'b1, 32'h0000_0068, 32'h1111_0068);
    access(1'b1, 32'h0000_00a8, 32'h2222_00a8);
    access(1'b1, 32'h0000_00e8, 32'h3333_00e8);
    access(1'b0, 32'h0000_0068, '0);
    finish_test("eviction", errs);

    errs = total_errors();
    for (int n = 0; n < N_RAND; n++)
    begin
      r = $random(seed);
      access(r[8], {24'h0, r[5:0], 2'b00}, $random(seed));
    end
    finish_test("random mix", errs);

    errs = total_errors();
    dp_req.halt = 1'b1;
    done        = 1'b0;
    while (!done)
    begin
      #(PERIOD / 2 - 1);
      done = dp_rsp.flushed;
      @(negedge CLK);
    end
    for (int i = 0; i < N_WORDS; i++)
      check_word(word_t'(i) << 2, shadow[i]);
    finish_test("flush", errs);

    errs = total_errors();
    check_word(STAT_ADDR, word_t'(first_hits));
    finish_test("hit statistic", errs);

    $display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, total_errors());
    if (tests_bad == 0 && total_errors() == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin
    #(LIMIT * PERIOD);
    $display("watchdog expired after %0d cycles, a request or the flush never finished", LIMIT);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- files.f
logic/cpu_types_pkg.sv
logic/dcache_array.sv
logic/dcache.sv
logic/ram.sv
logic/mem_subsystem.sv
testbench/dcache_assertions.sv
testbench/mem_subsystem_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = mem_subsystem_tb
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log
RUNFLAGS = +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) $(RUNFLAGS) 2>&1 | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
